// File: kyberArithPkg.sv
package kyberArithPkg;

  // ------------------------------
  // Ring parameters
  // ------------------------------

  // Kyber prime modulus
  localparam int KYBER_Q = 3329;

  // Coefficients per polynomial
  localparam int KYBER_N = 256;

  // Bits needed for a value below q
  localparam int COEF_W = 12;

  // ------------------------------
  // Coefficient types
  // ------------------------------

  // Reduced coefficient, always below q
  typedef logic [COEF_W-1:0] coef_t;

  // Position inside the polynomial, 0 to 255
  typedef logic [7:0] coefIdx_t;

  // Decoded value of a set message bit, (q+1)/2
  localparam coef_t MSG_ONE = coef_t'((KYBER_Q + 1) / 2);

endpackage

// File: kyberEncCtrlPkg.sv
package kyberEncCtrlPkg;

  // ------------------------------
  // Message format
  // ------------------------------

  // 32-byte message, one bit per coefficient
  localparam int MSG_BITS = 256;

  // Message bit i sits at vector bit i
  typedef logic [MSG_BITS-1:0] msg_t;

  // ------------------------------
  // Sequencer phases
  // ------------------------------

  // Idle waits for start
  // Stream runs all coefficients through the datapath
  // Flush lets the last packer write land
  // Done lasts one cycle and drives the done pulse
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STREAM,
    ST_FLUSH,
    ST_DONE
  } encState_t;

endpackage

// File: coefStreamIf.sv
`timescale 1ns/1ns

// One coefficient step between pipeline stages
// Decode instance carries the message coefficient
// Result instance carries the compressed value, step acts as valid
interface coefStreamIf
  import kyberArithPkg::*;
#(
  parameter int P_COEF_W = COEF_W
) ();

  // Single-cycle strobe for the fields below
  logic                step;
  // Coefficient position
  coefIdx_t            idx;
  // Payload, width set per instance
  logic [P_COEF_W-1:0] coef;
  // High with index 255
  logic                last;

  // Producer side
  modport source (output step, idx, coef, last);

  // Consumer side
  modport sink (input step, idx, coef, last);

endinterface

// File: msgDecoder.sv
`timescale 1ns/1ns

module msgDecoder
  import kyberArithPkg::*, kyberEncCtrlPkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         i_runStart,
  input  msg_t         i_msg,
  input  logic         i_ready,
  coefStreamIf.source  o_decode
);

  // Remaining message bits, LSB is the next one
  msg_t     msgShift;
  // Set for the whole run until index 255 has gone out
  logic     active;
  // Ready delayed by one cycle
  logic     readyDly;
  logic     stepQ;
  coefIdx_t idxQ;
  coef_t    coefQ;
  logic     lastQ;
  logic     advance;

  // Next step fires on the delayed ready
  assign advance = readyDly & active;

  // ------------------------------
  // Step control
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b0;
      readyDly <= 1'b0;
      stepQ    <= 1'b0;
    end else begin
      // A stale ready around run start is dropped
      readyDly <= i_ready & ~i_runStart;
      if (i_runStart) begin
        active <= 1'b1;
        stepQ  <= 1'b1;
      end else if (advance) begin
        stepQ <= 1'b1;
        // Index 255 is the final step of the run
        if (idxQ == coefIdx_t'(KYBER_N - 2)) begin
          active <= 1'b0;
        end
      end else begin
        stepQ <= 1'b0;
      end
    end
  end

  // ------------------------------
  // Coefficient payload
  // ------------------------------
  always_ff @(posedge clk) begin
    if (i_runStart) begin
      // Bit 0 goes out right away
      msgShift <= i_msg >> 1;
      coefQ    <= i_msg[0] ? MSG_ONE : '0;
      idxQ     <= '0;
      lastQ    <= 1'b0;
    end else if (advance) begin
      msgShift <= msgShift >> 1;
      coefQ    <= msgShift[0] ? MSG_ONE : '0;
      idxQ     <= idxQ + 1'b1;
      lastQ    <= (idxQ == coefIdx_t'(KYBER_N - 2));
    end
  end

  // Fields stay stable until the next step
  assign o_decode.step = stepQ;
  assign o_decode.idx  = idxQ;
  assign o_decode.coef = coefQ;
  assign o_decode.last = lastQ;

endmodule

// File: coefCompressor.sv
`timescale 1ns/1ns

module coefCompressor
  import kyberArithPkg::*;
#(
  parameter int P_DV = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  coefStreamIf.sink   i_decode,
  output logic        o_ready,
  output logic        o_coefReq,
  input  logic        i_coefAck,
  input  coef_t       i_polyCoef,
  input  coef_t       i_noiseCoef,
  coefStreamIf.source o_result
);

  // Handshake phases
  typedef enum logic [1:0] {
    CS_IDLE,
    CS_REQ,
    CS_ACK_LOW
  } cmpState_t;

  // Three operands below q need two extra bits
  localparam int SUM_W    = COEF_W + 2;
  // Value shifted by DV plus the rounding carry
  localparam int SCALED_W = COEF_W + P_DV + 1;

  localparam logic [SUM_W-1:0]    Q_SUM    = SUM_W'(KYBER_Q);
  localparam logic [SCALED_W-1:0] Q_SCALED = SCALED_W'(KYBER_Q);
  // Rounding offset, floor(q/2)
  localparam logic [SCALED_W-1:0] Q_HALF   = SCALED_W'(KYBER_Q / 2);

  cmpState_t         state;
  // Step seen while the previous handshake was still closing
  logic              stepPend;
  logic              reqQ;
  logic              readyQ;
  logic              capture;

  // Captured operands
  logic              capValid;
  coef_t             capMsg;
  coef_t             capPoly;
  coef_t             capNoise;
  coefIdx_t          capIdx;
  logic              capLast;

  // Adder and reduction
  logic [SUM_W-1:0]  sumRaw;
  logic [SUM_W-1:0]  sumOnce;
  logic [SUM_W-1:0]  sumTwice;
  coef_t             reduced;

  // Result stage
  logic              resValid;
  coefIdx_t          resIdx;
  logic [P_DV-1:0]   resValue;
  logic              resLast;

  // round(x * 2^DV / q) mod 2^DV
  function automatic logic [P_DV-1:0] compress(input coef_t x);
    logic [SCALED_W-1:0] scaled;
    logic [SCALED_W-1:0] quot;
    scaled = (SCALED_W'(x) << P_DV) + Q_HALF;
    quot   = scaled / Q_SCALED;
    return quot[P_DV-1:0];
  endfunction

  // First clock with ack high while requesting
  assign capture = (state == CS_REQ) & i_coefAck;

  // ------------------------------
  // Four-phase handshake
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= CS_IDLE;
      stepPend <= 1'b0;
      reqQ     <= 1'b0;
      readyQ   <= 1'b0;
      capValid <= 1'b0;
      resValid <= 1'b0;
    end else begin
      readyQ   <= 1'b0;
      capValid <= capture;
      resValid <= capValid;
      if (i_decode.step && (state != CS_IDLE)) begin
        stepPend <= 1'b1;
      end
      case (state)
        CS_IDLE: begin
          // Ack is known low here, so req may rise
          if (i_decode.step || stepPend) begin
            reqQ     <= 1'b1;
            stepPend <= 1'b0;
            state    <= CS_REQ;
          end
        end
        CS_REQ: begin
          // Waits as long as the producer needs
          if (i_coefAck) begin
            reqQ  <= 1'b0;
            state <= CS_ACK_LOW;
          end
        end
        CS_ACK_LOW: begin
          if (!i_coefAck) begin
            // No further coefficient after index 255
            readyQ <= ~capLast;
            state  <= CS_IDLE;
          end
        end
        default: state <= CS_IDLE;
      endcase
    end
  end

  // ------------------------------
  // Sum modulo q
  // ------------------------------
  always_comb begin
    sumRaw   = {2'b00, capMsg} + {2'b00, capPoly} + {2'b00, capNoise};
    sumOnce  = (sumRaw >= Q_SUM) ? sumRaw - Q_SUM : sumRaw;
    sumTwice = (sumOnce >= Q_SUM) ? sumOnce - Q_SUM : sumOnce;
    reduced  = sumTwice[COEF_W-1:0];
  end

  // Operand capture, then compressed result one cycle later
  always_ff @(posedge clk) begin
    if (capture) begin
      capMsg   <= i_decode.coef;
      capPoly  <= i_polyCoef;
      capNoise <= i_noiseCoef;
      capIdx   <= i_decode.idx;
      capLast  <= i_decode.last;
    end
    if (capValid) begin
      resIdx   <= capIdx;
      resValue <= compress(reduced);
      resLast  <= capLast;
    end
  end

  assign o_coefReq     = reqQ;
  assign o_ready       = readyQ;
  assign o_result.step = resValid;
  assign o_result.idx  = resIdx;
  assign o_result.coef = resValue;
  assign o_result.last = resLast;

endmodule

// File: cipherPacker.sv
`timescale 1ns/1ns

module cipherPacker
  import kyberArithPkg::*;
#(
  parameter int P_DV = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  coefStreamIf.sink               i_result,
  input  logic                    i_runStart,
  output logic                    o_packLast,
  output logic [KYBER_N*P_DV-1:0] o_cipher
);

  // Full v part of the ciphertext
  localparam int CIPHER_W = KYBER_N * P_DV;

  // Lowest bit of the current slot
  int   slotBase;
  logic writeEn;

  // Coefficient i lands at bits i*DV upward
  // For DV = 4 this gives two nibbles per byte, low nibble first
  assign slotBase = int'(i_result.idx) * P_DV;
  assign writeEn  = i_result.step;

  // ------------------------------
  // Cipher buffer
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_cipher <= '0;
    end else if (i_runStart) begin
      // Fresh run starts from zero
      o_cipher <= {CIPHER_W{1'b0}};
    end else if (writeEn) begin
      o_cipher[slotBase +: P_DV] <= i_result.coef;
    end
  end

  // Final write is under way in this cycle
  // Buffer holds it from the next edge on
  assign o_packLast = i_result.step & i_result.last;

endmodule

// File: encSequencer.sv
`timescale 1ns/1ns

module encSequencer
  import kyberEncCtrlPkg::*;
(
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_start,
  input  logic i_packLast,
  output logic o_runStart,
  output logic o_done,
  output logic o_busy
);

  encState_t state;
  encState_t nextState;
  logic      startAccept;
  logic      runStartQ;

  // Any phase other than idle locks out a new start
  assign o_busy      = (state != ST_IDLE);
  assign startAccept = i_start & ~o_busy;

  // ------------------------------
  // Next phase
  // ------------------------------
  always_comb begin
    nextState = state;
    case (state)
      ST_IDLE: begin
        if (startAccept) begin
          nextState = ST_STREAM;
        end
      end
      ST_STREAM: begin
        // Last compressed value is being packed
        if (i_packLast) begin
          nextState = ST_FLUSH;
        end
      end
      // One cycle for the last write to land
      ST_FLUSH: nextState = ST_DONE;
      ST_DONE:  nextState = ST_IDLE;
      default:  nextState = ST_IDLE;
    endcase
  end

  // ------------------------------
  // Phase register
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= nextState;
    end
  end

  // Run start pulse one cycle after start is taken
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      runStartQ <= 1'b0;
    end else begin
      runStartQ <= startAccept;
    end
  end

  assign o_runStart = runStartQ;

  // Done pulse, three cycles after the final capture
  assign o_done = (state == ST_DONE);

endmodule

// File: kyberEncTail.sv
`timescale 1ns/1ns

module kyberEncTail
  import kyberArithPkg::*, kyberEncCtrlPkg::*;
#(
  // Compression bits for v, 4 in Kyber512
  parameter int P_DV = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_start,
  input  msg_t                    i_msg,
  output logic                    o_coefReq,
  input  logic                    i_coefAck,
  input  coef_t                   i_polyCoef,
  input  coef_t                   i_noiseCoef,
  output logic [KYBER_N*P_DV-1:0] o_cipher,
  output logic                    o_done
);

  logic runStart;
  logic packLast;
  logic coefReady;

  // Decoded message coefficients
  coefStreamIf decodeIf ();
  // Compressed values, DV bits wide
  coefStreamIf #(.P_COEF_W(P_DV)) resultIf ();

  // ------------------------------
  // Phase control
  // ------------------------------
  encSequencer uSequencer (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_start    (i_start),
    .i_packLast (packLast),
    .o_runStart (runStart),
    .o_done     (o_done),
    .o_busy     ()
  );

  // ------------------------------
  // Datapath
  // ------------------------------
  msgDecoder uDecoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_runStart (runStart),
    .i_msg      (i_msg),
    .i_ready    (coefReady),
    .o_decode   (decodeIf)
  );

  coefCompressor #(
    .P_DV (P_DV)
  ) uCompressor (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_decode    (decodeIf),
    .o_ready     (coefReady),
    .o_coefReq   (o_coefReq),
    .i_coefAck   (i_coefAck),
    .i_polyCoef  (i_polyCoef),
    .i_noiseCoef (i_noiseCoef),
    .o_result    (resultIf)
  );

  cipherPacker #(
    .P_DV (P_DV)
  ) uPacker (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_result   (resultIf),
    .i_runStart (runStart),
    .o_packLast (packLast),
    .o_cipher   (o_cipher)
  );

endmodule

// File: tbChecker.sv
`timescale 1ns/1ns

module tbChecker
  import kyberArithPkg::*, kyberEncCtrlPkg::*;
#(
  parameter int P_DV = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_start,
  input  msg_t                    i_msg,
  input  logic                    i_coefReq,
  input  logic                    i_coefAck,
  input  coef_t                   i_polyCoef,
  input  coef_t                   i_noiseCoef,
  input  logic [KYBER_N*P_DV-1:0] i_cipher,
  input  logic                    i_done,
  output int                      o_errors,
  output int                      o_runsDone
);

  localparam int CIPHER_W   = KYBER_N * P_DV;
  // Cycles from the last capture edge to the done cycle
  localparam int DONE_LAT   = 3;
  // Decoded value of a set message bit is (q+1)/2
  localparam int DECODE_ONE = 1665;

  logic                busy;
  logic                idleNow;
  logic                started;
  logic                prevReq;
  logic                prevAck;
  logic                prevDone;
  logic                holdBad;
  msg_t                msgQ;
  int                  capCount;
  int                  capCycle;
  int                  cycle;
  int                  runIdx;
  logic [CIPHER_W-1:0] expCipher;
  logic [CIPHER_W-1:0] heldCipher;

  // Rounded x*2^DV/q as floor((2*x*2^DV + q) / 2q) and taken mod 2^DV
  function automatic int roundCompress(input int x);
    return ((2 * x * (1 << P_DV) + KYBER_Q) / (2 * KYBER_Q)) % (1 << P_DV);
  endfunction

  function automatic int expectedNibble(input logic msgBit, input int poly, input int noise);
    int m;
    m = msgBit ? DECODE_ONE : 0;
    return roundCompress((m + poly + noise) % KYBER_Q);
  endfunction

  task reportMismatch(input string testName, input int expVal, input int actVal);
    $display("[FAIL] %s (run %0d): expected %0d, actual %0d", testName, runIdx, expVal, actVal);
    o_errors = o_errors + 1;
  endtask

  task reportProblem(input string what);
    $display("Error in run %0d: %s", runIdx, what);
    o_errors = o_errors + 1;
  endtask

  // Shows the lowest coefficient slot that differs
  task reportCipher;
    int k;
    int firstBad;
    firstBad = 0;
    for (k = KYBER_N - 1; k >= 0; k--) begin
      if (expCipher[k*P_DV +: P_DV] !== i_cipher[k*P_DV +: P_DV]) begin
        firstBad = k;
      end
    end
    $display("[FAIL] cipher (run %0d, coefficient %0d): expected %h, actual %h", runIdx,
             firstBad, expCipher[firstBad*P_DV +: P_DV], i_cipher[firstBad*P_DV +: P_DV]);
    o_errors = o_errors + 1;
  endtask

  // ------------------------------
  // Port monitor on pre-edge values
  // ------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      busy       = 1'b0;
      started    = 1'b0;
      prevReq    = 1'b0;
      prevAck    = 1'b0;
      prevDone   = 1'b0;
      holdBad    = 1'b0;
      capCount   = 0;
      capCycle   = 0;
      cycle      = 0;
      runIdx     = 0;
      o_errors   = 0;
      o_runsDone = 0;
      expCipher  = '0;
      heldCipher = '0;
    end else begin
      cycle   = cycle + 1;
      idleNow = !busy;
      // Quiet outputs until the first start
      if (!started && (i_coefReq !== 1'b0 || i_done !== 1'b0 || i_cipher !== '0)) begin
        reportProblem("outputs not idle after reset");
      end
      // Four-phase ordering
      if (i_coefReq && !prevReq && prevAck) begin
        reportProblem("request raised while acknowledge was still high");
      end
      if (!i_coefReq && prevReq && !prevAck) begin
        reportProblem("request dropped without an acknowledge");
      end
      // Capture happens on this edge
      if (i_coefReq && i_coefAck) begin
        if (!busy) begin
          reportProblem("coefficient captured outside a run");
        end else if (capCount >= KYBER_N) begin
          reportProblem("more than 256 coefficients captured in one run");
        end else begin
          // Run start wipes the previous cipher before any write
          if (capCount == 0 && i_cipher !== '0) begin
            reportProblem("cipher not cleared at run start");
          end
          expCipher[capCount*P_DV +: P_DV] =
            expectedNibble(msgQ[capCount], int'(i_polyCoef), int'(i_noiseCoef));
          if (capCount == KYBER_N - 1) begin
            capCycle = cycle;
          end
          capCount = capCount + 1;
        end
      end
      // Done closes the run and fixes the held cipher
      if (i_done) begin
        if (prevDone) begin
          reportProblem("done held high for more than one cycle");
        end else if (!busy) begin
          reportProblem("done pulse without an active run");
        end else begin
          if (capCount != KYBER_N) begin
            reportMismatch("capture count", KYBER_N, capCount);
          end else if (cycle - 1 - capCycle != DONE_LAT) begin
            reportMismatch("done latency", DONE_LAT, cycle - 1 - capCycle);
          end
          if (i_cipher !== expCipher) begin
            reportCipher();
          end
          heldCipher = i_cipher;
          holdBad    = 1'b0;
          busy       = 1'b0;
          o_runsDone = o_runsDone + 1;
        end
      end else if (busy && capCount == KYBER_N && cycle - 1 - capCycle == DONE_LAT + 1) begin
        reportProblem("done did not follow the last capture");
      end else if (!busy && o_runsDone > 0 && !holdBad && i_cipher !== heldCipher) begin
        reportProblem("cipher changed before the next start");
        holdBad = 1'b1;
      end
      // Start is taken only when the DUT was idle before this edge
      if (idleNow && i_start) begin
        busy      = 1'b1;
        started   = 1'b1;
        msgQ      = i_msg;
        capCount  = 0;
        expCipher = '0;
        runIdx    = runIdx + 1;
      end
      prevReq  = i_coefReq;
      prevAck  = i_coefAck;
      prevDone = i_done;
    end
  end

endmodule

// File: tbKyberEncTail.sv
`timescale 1ns/1ns

module tbKyberEncTail
  import kyberArithPkg::*, kyberEncCtrlPkg::*;
();

  localparam int DV             = 4;
  localparam int NUM_RUNS       = 6;
  localparam int RESET_CYCLES   = 8;
  // At most 12 cycles per coefficient with the slowest producer
  localparam int TIMEOUT_CYCLES = NUM_RUNS * KYBER_N * 12 + RESET_CYCLES;
  // Producer value modes
  localparam int MODE_RANDOM    = 0;
  localparam int MODE_MAX       = 1;
  localparam int MODE_ZERO      = 2;

  logic                clk;
  logic                rst_n;
  logic                i_start;
  msg_t                i_msg;
  logic                o_coefReq;
  logic                i_coefAck;
  coef_t               i_polyCoef;
  coef_t               i_noiseCoef;
  logic [KYBER_N*DV-1:0] o_cipher;
  logic                o_done;
  int                  checkErrors;
  int                  runsDone;
  int                  driverErrors;
  int                  pairsSent;
  int                  cycleCount;
  int                  coefMode;

  kyberEncTail #(.P_DV(DV)) i_kyberEncTail (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .i_msg       (i_msg),
    .o_coefReq   (o_coefReq),
    .i_coefAck   (i_coefAck),
    .i_polyCoef  (i_polyCoef),
    .i_noiseCoef (i_noiseCoef),
    .o_cipher    (o_cipher),
    .o_done      (o_done)
  );

  tbChecker #(.P_DV(DV)) uChecker (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .i_msg       (i_msg),
    .i_coefReq   (o_coefReq),
    .i_coefAck   (i_coefAck),
    .i_polyCoef  (i_polyCoef),
    .i_noiseCoef (i_noiseCoef),
    .i_cipher    (o_cipher),
    .i_done      (o_done),
    .o_errors    (checkErrors),
    .o_runsDone  (runsDone)
  );

  always #5 clk = ~clk;

  // Hard stop on a stuck run
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT did not finish its runs", cycleCount);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic coef_t pickCoef();
    case (coefMode)
      MODE_MAX:  return coef_t'(KYBER_Q - 1);
      MODE_ZERO: return '0;
      default:   return coef_t'($urandom % KYBER_Q);
    endcase
  endfunction

  function automatic msg_t randomMsg();
    msg_t m;
    for (int w = 0; w < MSG_BITS / 32; w++) begin
      m[w*32 +: 32] = $urandom;
    end
    return m;
  endfunction

  // ------------------------------
  // Coefficient producer
  // ------------------------------
  initial begin : producer
    int waitCycles;
    int holdCycles;
    forever begin
      @(negedge clk);
      if (rst_n && o_coefReq) begin
        // Slow ack is the only back-pressure
        waitCycles = $urandom % 6;
        repeat (waitCycles) @(negedge clk);
        i_polyCoef  = pickCoef();
        i_noiseCoef = pickCoef();
        i_coefAck   = 1'b1;
        pairsSent   = pairsSent + 1;
        do @(negedge clk); while (o_coefReq);
        // Ack may linger after req falls
        holdCycles = $urandom % 3;
        repeat (holdCycles) @(negedge clk);
        i_coefAck = 1'b0;
      end
    end
  end

  // One full encryption tail with an optional ignored second start
  task automatic runEncryption(input msg_t msg, input int mode, input int idleCycles,
                               input bit midStart);
    coefMode = mode;
    repeat (idleCycles) @(negedge clk);
    @(negedge clk);
    i_start = 1'b1;
    i_msg   = msg;
    @(negedge clk);
    i_start = 1'b0;
    if (midStart) begin
      // Well inside the run
      repeat (300) @(negedge clk);
      i_start = 1'b1;
      i_msg   = ~msg;
      @(negedge clk);
      i_start = 1'b0;
    end
    do @(negedge clk); while (!o_done);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int seed;
    seed = 77;
    void'($urandom(seed));
    clk          = 1'b0;
    rst_n        = 1'b0;
    i_start      = 1'b0;
    i_msg        = '0;
    i_coefAck    = 1'b0;
    i_polyCoef   = '0;
    i_noiseCoef  = '0;
    cycleCount   = 0;
    pairsSent    = 0;
    driverErrors = 0;
    coefMode     = MODE_RANDOM;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    // Quiet window for the reset check
    repeat (4) @(negedge clk);
    runEncryption(randomMsg(), MODE_RANDOM, 0, 1'b0);
    // Two subtractions needed
    runEncryption({MSG_BITS{1'b1}}, MODE_MAX, 3, 1'b0);
    // Sum 3327 compresses to 16 and wraps to 0
    runEncryption('0, MODE_MAX, 2, 1'b0);
    runEncryption({MSG_BITS{1'b1}}, MODE_ZERO, 5, 1'b0);
    runEncryption(randomMsg(), MODE_RANDOM, 1, 1'b1);
    // Restart on the first idle cycle
    runEncryption(randomMsg(), MODE_RANDOM, 0, 1'b0);
    repeat (10) @(negedge clk);
    if (pairsSent != NUM_RUNS * KYBER_N) begin
      $display("[FAIL] pair count: expected %0d, actual %0d", NUM_RUNS * KYBER_N, pairsSent);
      driverErrors = driverErrors + 1;
    end
    if (runsDone != NUM_RUNS) begin
      $display("[FAIL] run count: expected %0d, actual %0d", NUM_RUNS, runsDone);
      driverErrors = driverErrors + 1;
    end
    $display("Errors: %0d from checker, %0d from driver", checkErrors, driverErrors);
    if (checkErrors + driverErrors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
kyberArithPkg.sv
kyberEncCtrlPkg.sv
coefStreamIf.sv
msgDecoder.sv
coefCompressor.sv
cipherPacker.sv
encSequencer.sv
kyberEncTail.sv
tbChecker.sv
tbKyberEncTail.sv
